// ==== tb.f ====
src/rom_load_pkg.sv
src/rom_header_regs.sv
src/rom_region_decode.sv
src/scr_tile_regroup.sv
src/rewrite_seq_fsm.sv
src/scr_addr_counter.sv
src/rom_loader_top.sv
dv/rom_loader_chk.sv
dv/rom_loader_tb.sv

// ==== Bender.yml ====
package:
  name: rom_loader

sources:
  - src/rom_load_pkg.sv
  - src/rom_header_regs.sv
  - src/rom_region_decode.sv
  - src/scr_tile_regroup.sv
  - src/rewrite_seq_fsm.sv
  - src/scr_addr_counter.sv
  - src/rom_loader_top.sv
  - target: test
    files:
      - dv/rom_loader_chk.sv
      - dv/rom_loader_tb.sv

// ==== dv/rom_loader_tb.sv ====
// ROM loader testbench
`default_nettype none

module rom_loader_tb;

    import rom_load_pkg::*;

    localparam logic [addr_w-1:0] snd_pg  = 22'd1; // region starts written into the header.
    localparam logic [addr_w-1:0] char_pg = 22'd2;
    localparam logic [addr_w-1:0] scr_pg  = 22'd3;
    localparam logic [addr_w-1:0] obj_pg  = 22'd4;
    localparam logic [63:0] starts_word   = 64'h0001_0002_0003_0004;

    logic              clk;
    logic              rst;
    logic              downloading;
    logic [addr_w-1:0] ioctl_addr;
    logic [7:0]        ioctl_data;
    logic              ioctl_wr;
    logic              sdram_ack = 1'b0;
    prog_req_t         prog;
    logic              prog_we;
    logic [7:0]        game_cfg;

    integer            seed = 32'hb7b3b95a;
    logic [7:0]        pool [64];
    int                pool_idx = 0;
    prog_req_t         q [$]; // expected SDRAM writes in issue order.
    logic [7:0]        cfg_exp;
    logic [7:0]        scr_grp [4];
    logic [addr_w-1:0] scr_next = scr_base;
    logic              late_ack = 1'b0;
    logic              hold_ack = 1'b0;
    logic              armed = 1'b0;
    int                ack_delay = 0;

    rom_loader_top u_dut (
        .clk, .rst, .downloading, .ioctl_addr, .ioctl_data, .ioctl_wr, .sdram_ack,
        .prog, .prog_we, .game_cfg
    );

    bind rom_loader_top rom_loader_chk u_chk (
        .clk, .rst, .downloading, .sdram_ack, .prog_we, .prog
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    function automatic prog_req_t expect_direct(input logic [addr_w-1:0] bulk,
                                                input logic [7:0] data);
        logic [addr_w-1:0] offset;
        logic [addr_w-1:0] base;
        logic              swap;
        prog_req_t         req;
        if ((bulk >> 8) >= obj_pg) begin
            offset = bulk - (obj_pg << 8);
            base   = obj_base;
            swap   = 1'b0;
        end else if ((bulk >> 8) >= char_pg) begin
            offset = bulk - (char_pg << 8);
            base   = char_base;
            swap   = 1'b0;
        end else if ((bulk >> 8) >= snd_pg) begin
            offset = bulk - (snd_pg << 8);
            base   = snd_base;
            swap   = 1'b1;
        end else begin
            offset = bulk;
            base   = cpu_base;
            swap   = 1'b1;
        end
        req.addr = (offset >> 1) + base;
        req.data = data;
        req.mask = (offset[0] ^ swap) ? 2'b10 : 2'b01; // plain parity masks low on even.
        return req;
    endfunction

    // four nibble-regrouped rewrites, two per scroll word.
    task automatic push_scroll_group();
        prog_req_t req;
        req.addr = scr_next;
        req.mask = 2'b10;
        req.data = {scr_grp[1][7:4], scr_grp[0][7:4]};
        q.push_back(req);
        req.mask = 2'b01;
        req.data = {scr_grp[3][7:4], scr_grp[2][7:4]};
        q.push_back(req);
        req.addr = scr_next + 1'b1;
        req.mask = 2'b10;
        req.data = {scr_grp[1][3:0], scr_grp[0][3:0]};
        q.push_back(req);
        req.mask = 2'b01;
        req.data = {scr_grp[3][3:0], scr_grp[2][3:0]};
        q.push_back(req);
        scr_next = scr_next + 2'd2;
    endtask

    task automatic send_byte(input logic [addr_w-1:0] addr);
        logic [7:0]        data;
        logic [addr_w-1:0] bulk;
        data = pool[pool_idx];
        pool_idx++;
        bulk = addr - header_len;
        if (addr >= starts_first && addr <= starts_last) begin
            data = starts_word[(starts_last - addr) * 8 +: 8];
        end
        if (addr == 0) begin
            cfg_exp = data;
        end
        if (addr >= header_len && (bulk >> 8) >= scr_pg && (bulk >> 8) < obj_pg) begin
            scr_grp[bulk[1:0]] = data;
            if (bulk[1:0] == 2'd3) begin
                push_scroll_group();
            end
        end else begin
            scr_next = scr_base; // any other byte restarts the scroll words.
            if (addr >= header_len) begin
                q.push_back(expect_direct(bulk, data));
            end
        end
        @(negedge clk);
        ioctl_addr = addr;
        ioctl_data = data;
        ioctl_wr   = 1'b1;
        @(negedge clk);
        ioctl_wr   = 1'b0;
    endtask

    task automatic wait_done();
        int cycles;
        cycles = 0;
        while (q.size() != 0 || prog_we) begin
            @(negedge clk);
            cycles++;
            if (cycles > 100) begin
                fail_now("timeout while waiting for the pending SDRAM writes");
            end
        end
        @(negedge clk); // the FSM needs a cycle to return to idle.
    endtask

    task automatic wait_we_high();
        int cycles;
        cycles = 0;
        while (!prog_we) begin
            @(negedge clk);
            cycles++;
            if (cycles > 20) begin
                fail_now("timeout while waiting for prog_we to rise");
            end
        end
    endtask

    task automatic send_range(input logic [addr_w-1:0] first, input int count);
        for (int i = 0; i < count; i++) begin
            send_byte(first + addr_w'(i));
            wait_done();
        end
    endtask

    task automatic check_write();
        prog_req_t exp;
        assert (q.size() > 0) else fail_now("a write request arrived with no expected entry");
        exp = q.pop_front();
        assert (prog.addr == exp.addr) else fail_now($sformatf(
            "error at %0t: prog.addr is %h, expected %h", $time, prog.addr, exp.addr));
        assert (prog.data == exp.data) else fail_now($sformatf(
            "error at %0t: prog.data is %h, expected %h", $time, prog.data, exp.data));
        assert (prog.mask == exp.mask) else fail_now($sformatf(
            "error at %0t: prog.mask is %b, expected %b", $time, prog.mask, exp.mask));
    endtask

    // SDRAM side answers each write after a random delay.
    always @(negedge clk) begin
        if (u_dut.u_chk.err_count != 0) begin
            fail_now("a protocol assertion in the bound checker failed");
        end else if (sdram_ack) begin
            sdram_ack = 1'b0;
        end else if (prog_we && !hold_ack) begin
            if (!armed) begin
                armed     = 1'b1;
                ack_delay = late_ack ? 8 : 1 + $unsigned($random(seed)) % 4;
            end else begin
                ack_delay = ack_delay - 1;
                if (ack_delay == 0) begin
                    check_write();
                    sdram_ack = 1'b1;
                    armed     = 1'b0;
                end
            end
        end else if (armed) begin
            fail_now("prog_we fell before the SDRAM acknowledge");
        end
    end

    initial begin
        rst         = 1'b1;
        downloading = 1'b0;
        ioctl_addr  = '0;
        ioctl_data  = 8'h00;
        ioctl_wr    = 1'b0;
        for (int i = 0; i < 64; i++) begin
            pool[i] = $random(seed);
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst         = 1'b0;
        downloading = 1'b1;
        send_range('0, header_len);
        assert (game_cfg == cfg_exp) else fail_now($sformatf(
            "error at %0t: game_cfg is %h, expected %h", $time, game_cfg, cfg_exp));
        send_range(header_len + 22'h000, 4); // cpu bytes, both lanes.
        send_range(header_len + 22'h100, 3);
        send_range(header_len + 22'h200, 1);
        late_ack = 1'b1;
        send_range(header_len + 22'h201, 1);
        late_ack = 1'b0;
        send_range(header_len + 22'h202, 1);
        send_range(header_len + 22'h300, 4); // two scroll groups back to back.
        send_range(header_len + 22'h304, 4);
        send_range(header_len + 22'h400, 2);
        send_range(header_len + 22'h308, 4); // starts again at the scroll base.
        hold_ack = 1'b1;
        send_byte(header_len + 22'h402);
        wait_we_high();
        downloading = 1'b0; // abandons the pending object write.
        @(negedge clk);
        assert (prog_we == 1'b0) else fail_now($sformatf(
            "error at %0t: prog_we is %b, expected 0", $time, prog_we));
        void'(q.pop_front());
        if (q.size() != 0) begin
            fail_now($sformatf("%0d expected writes never reached the SDRAM", q.size()));
        end else if (u_dut.u_chk.err_count != 0) begin
            fail_now("a protocol assertion in the bound checker failed");
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== dv/rom_loader_chk.sv ====
// ROM loader protocol checks
`default_nettype none

module rom_loader_chk (
    input logic                    clk,
    input logic                    rst,
    input logic                    downloading,
    input logic                    sdram_ack,
    input logic                    prog_we,
    input rom_load_pkg::prog_req_t prog
);

    int err_count = 0; // failed assertions so far.

    a_reset_quiet: assert property (@(posedge clk) rst |=> !prog_we)
        else begin
            err_count++;
            $error("prog_we is high in the cycle after reset");
        end

    a_ack_drops_we: assert property (@(posedge clk) disable iff (rst) sdram_ack |=> !prog_we)
        else begin
            err_count++;
            $error("prog_we stays high in the cycle after sdram_ack");
        end

    // a write holds its request until the acknowledge or the end of the download.
    a_prog_held: assert property (@(posedge clk) disable iff (rst)
        prog_we && !sdram_ack |=> (prog_we && $stable(prog)) || !downloading)
        else begin
            err_count++;
            $error("prog_we or prog changed before sdram_ack");
        end

    a_one_lane: assert property (@(posedge clk) disable iff (rst)
        prog_we |-> (prog.mask == 2'b01) || (prog.mask == 2'b10))
        else begin
            err_count++;
            $error("prog.mask does not select exactly one byte lane");
        end

endmodule

`default_nettype wire

// ==== src/rom_loader_top.sv ====
// ROM loader top level
`default_nettype none

module rom_loader_top (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            downloading,
    input  logic [rom_load_pkg::addr_w-1:0] ioctl_addr,
    input  logic [7:0]                      ioctl_data,
    input  logic                            ioctl_wr,
    input  logic                            sdram_ack,
    output rom_load_pkg::prog_req_t         prog,
    output logic                            prog_we,
    output logic [7:0]                      game_cfg
);

    import rom_load_pkg::*;

    logic              accept;
    logic              in_header;
    logic              is_scr;
    logic              group_full;
    logic              sel_scr;
    logic              cnt_load;
    logic              cnt_advance;
    region_starts_u    starts;
    region_e           region;
    rewrite_step_t     step;
    prog_req_t         direct_req;
    prog_req_t         scr_req;
    logic [7:0]        scr_byte;
    logic [1:0]        scr_mask;
    logic [addr_w-1:0] scr_addr;

    assign accept = ioctl_wr && downloading;
    assign is_scr = !in_header && (region == rgn_scr);

    rom_header_regs u_header (
        .clk, .rst, .accept, .ioctl_addr, .ioctl_data, .game_cfg, .starts
    );

    rom_region_decode u_decode (
        .ioctl_addr, .ioctl_data, .starts, .in_header, .region, .direct_req
    );

    scr_tile_regroup u_regroup (
        .clk, .rst, .accept, .is_scr, .ioctl_addr(ioctl_addr[1:0]), .ioctl_data,
        .step, .group_full, .scr_byte, .scr_mask
    );

    rewrite_seq_fsm u_fsm (
        .clk, .rst, .downloading, .accept, .in_header, .region, .group_full,
        .sdram_ack, .prog_we, .sel_scr, .step, .cnt_load, .cnt_advance
    );

    scr_addr_counter u_scr_cnt (
        .clk, .rst, .load(cnt_load), .advance(cnt_advance), .scr_addr
    );

    always_comb begin
        scr_req.addr = scr_addr;
        scr_req.data = scr_byte;
        scr_req.mask = scr_mask;
    end

    // the request is captured on the edge that raises prog_we and then held.
    always_ff @(posedge clk) begin
        if (!prog_we) begin
            prog <= sel_scr ? scr_req : direct_req;
        end
    end

endmodule

`default_nettype wire

// ==== src/scr_addr_counter.sv ====
// Scroll address counter
`default_nettype none

module scr_addr_counter (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            load,
    input  logic                            advance,
    output logic [rom_load_pkg::addr_w-1:0] scr_addr
);

    import rom_load_pkg::*;

    always_ff @(posedge clk) begin
        if (rst) begin
            scr_addr <= scr_base;
        end else if (load) begin
            scr_addr <= scr_base; // scroll data restarts at the region base.
        end else if (advance) begin
            scr_addr <= scr_addr + 1'b1; // one word per pair of rewrites.
        end
    end

endmodule

`default_nettype wire

// ==== src/rewrite_seq_fsm.sv ====
// Write sequencer FSM
`default_nettype none

module rewrite_seq_fsm (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        downloading,
    input  logic                        accept,
    input  logic                        in_header,
    input  rom_load_pkg::region_e       region,
    input  logic                        group_full,
    input  logic                        sdram_ack,
    output logic                        prog_we,
    output logic                        sel_scr,
    output rom_load_pkg::rewrite_step_t step,
    output logic                        cnt_load,
    output logic                        cnt_advance
);

    import rom_load_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_direct,
        st_scr_pend,
        st_scr_write,
        st_scr_wait
    } state_e;

    state_e state;
    logic   we_q;
    logic   direct_byte;
    logic   other_byte;

    assign direct_byte = accept && !in_header && (region != rgn_scr);
    assign other_byte  = accept && (in_header || (region != rgn_scr));
    assign sel_scr     = (state == st_scr_pend) || (state == st_scr_write)
                      || (state == st_scr_wait);
    assign prog_we     = we_q && downloading; // the end of the download drops it at once.

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= st_idle;
            we_q        <= 1'b0;
            step        <= '0;
            cnt_load    <= 1'b0;
            cnt_advance <= 1'b0;
        end else begin
            cnt_load    <= 1'b0;
            cnt_advance <= 1'b0;
            if (!downloading) begin
                state <= st_idle; // an unfinished write is abandoned.
                we_q  <= 1'b0;
                step  <= '0;
            end else begin
                case (state)
                    st_idle: begin
                        cnt_load <= other_byte;
                        if (group_full) begin
                            state <= st_scr_pend;
                        end else if (direct_byte) begin
                            we_q  <= 1'b1;
                            state <= st_direct;
                        end
                    end
                    st_direct: begin
                        if (sdram_ack) begin
                            we_q  <= 1'b0;
                            state <= st_idle;
                        end
                    end
                    st_scr_pend: begin
                        if (!accept) begin
                            we_q  <= 1'b1; // host bytes keep priority on the bus.
                            state <= st_scr_write;
                        end
                    end
                    st_scr_write: begin
                        if (sdram_ack) begin
                            we_q        <= 1'b0;
                            cnt_advance <= step[0];
                            step        <= step + 2'd1;
                            state       <= st_scr_wait;
                        end
                    end
                    st_scr_wait: begin
                        // step wraps to 0 after the fourth rewrite.
                        state <= (step == 2'd0) ? st_idle : st_scr_pend;
                    end
                    default: begin
                        state <= st_idle;
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/scr_tile_regroup.sv ====
// Scroll tile nibble regroup
`default_nettype none

module scr_tile_regroup (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        accept,
    input  logic                        is_scr,
    input  logic [1:0]                  ioctl_addr,
    input  logic [7:0]                  ioctl_data,
    input  rom_load_pkg::rewrite_step_t step,
    output logic                        group_full,
    output logic [7:0]                  scr_byte,
    output logic [1:0]                  scr_mask
);

    logic [3:0][7:0] shift_q; // byte 0 is the oldest of the last four.

    always_ff @(posedge clk) begin
        if (accept) begin
            shift_q <= {ioctl_data, shift_q[3:1]};
        end
    end

    // the group closes on the byte at the top of a 4-byte block.
    always_ff @(posedge clk) begin
        if (rst) begin
            group_full <= 1'b0;
        end else begin
            group_full <= accept && is_scr && (ioctl_addr == 2'd3);
        end
    end

    // steps 0 and 1 take high nibbles, odd steps pair bytes 3 and 2.
    always_comb begin
        case (step)
            2'd0: begin
                scr_byte = {shift_q[1][7:4], shift_q[0][7:4]};
            end
            2'd1: begin
                scr_byte = {shift_q[3][7:4], shift_q[2][7:4]};
            end
            2'd2: begin
                scr_byte = {shift_q[1][3:0], shift_q[0][3:0]};
            end
            default: begin
                scr_byte = {shift_q[3][3:0], shift_q[2][3:0]};
            end
        endcase
    end

    assign scr_mask = step[0] ? 2'b01 : 2'b10; // even steps write the low lane.

endmodule

`default_nettype wire

// ==== src/rom_region_decode.sv ====
// ROM region decoder
`default_nettype none

module rom_region_decode (
    input  logic [rom_load_pkg::addr_w-1:0] ioctl_addr,
    input  logic [7:0]                      ioctl_data,
    input  rom_load_pkg::region_starts_u    starts,
    output logic                            in_header,
    output rom_load_pkg::region_e           region,
    output rom_load_pkg::prog_req_t         direct_req
);

    import rom_load_pkg::*;

    function automatic logic [addr_w-1:0] page_to_addr(input logic [15:0] page);
        page_to_addr = addr_w'({page, 8'h00});
    endfunction

    region_pages_t     pg;
    logic [addr_w-1:0] bulk_addr;
    logic [15:0]       page;
    logic [addr_w-1:0] offset;
    logic [addr_w-1:0] base;
    logic              swap_lane;

    assign pg        = starts.pages;
    assign bulk_addr = ioctl_addr - addr_w'(header_len); // header bytes are not stored.
    assign page      = 16'(bulk_addr[addr_w-1:8]);
    assign in_header = ioctl_addr < addr_w'(header_len);

    always_comb begin
        if (page >= pg.obj_start) begin
            region = rgn_obj;
        end else if (page >= pg.scr_start) begin
            region = rgn_scr;
        end else if (page >= pg.char_start) begin
            region = rgn_char;
        end else if (page >= pg.snd_start) begin
            region = rgn_snd;
        end else begin
            region = rgn_cpu;
        end
    end

    always_comb begin
        case (region)
            rgn_snd: begin
                offset = bulk_addr - page_to_addr(pg.snd_start);
                base   = snd_base;
            end
            rgn_char: begin
                offset = bulk_addr - page_to_addr(pg.char_start);
                base   = char_base;
            end
            rgn_obj: begin
                offset = bulk_addr - page_to_addr(pg.obj_start);
                base   = obj_base;
            end
            default: begin
                offset = bulk_addr; // cpu data keeps its bulk position.
                base   = cpu_base;
            end
        endcase
    end

    // the cpu and sound buses read their bytes in the opposite lane order.
    assign swap_lane = (region == rgn_cpu) || (region == rgn_snd);

    always_comb begin
        direct_req.addr = {1'b0, offset[addr_w-1:1]} + base;
        direct_req.data = ioctl_data;
        direct_req.mask = (bulk_addr[0] ^ swap_lane) ? 2'b10 : 2'b01;
    end

endmodule

`default_nettype wire

// ==== src/rom_header_regs.sv ====
// ROM header registers
`default_nettype none

module rom_header_regs (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             accept,
    input  logic [rom_load_pkg::addr_w-1:0]  ioctl_addr,
    input  logic [7:0]                       ioctl_data,
    output logic [7:0]                       game_cfg,
    output rom_load_pkg::region_starts_u     starts
);

    import rom_load_pkg::*;

    logic is_cfg;
    logic is_start;

    assign is_cfg   = accept && (ioctl_addr == '0);
    assign is_start = accept && (ioctl_addr >= addr_w'(starts_first))
                             && (ioctl_addr <= addr_w'(starts_last));

    always_ff @(posedge clk) begin
        if (rst) begin
            game_cfg <= 8'h00;
        end else if (is_cfg) begin
            game_cfg <= ioctl_data; // header byte 0 selects the game variant.
        end
    end

    // the first start byte travels up to the most significant position.
    always_ff @(posedge clk) begin
        if (rst) begin
            starts <= '0;
        end else if (is_start) begin
            starts.bytes <= {starts.bytes[6:0], ioctl_data};
        end
    end

endmodule

`default_nettype wire

// ==== src/rom_load_pkg.sv ====
// ROM loader definitions
`default_nettype none

package rom_load_pkg;

    localparam int addr_w       = 22;
    localparam int header_len   = 32; // bytes ahead of the bulk data.
    localparam int starts_first = 8;  // first header byte of the region starts.
    localparam int starts_last  = 15; // last header byte of the region starts.

    localparam logic [addr_w-1:0] cpu_base  = 22'h000000; // SDRAM word bases.
    localparam logic [addr_w-1:0] snd_base  = 22'h008000;
    localparam logic [addr_w-1:0] char_base = 22'h00c000;
    localparam logic [addr_w-1:0] scr_base  = 22'h010000;
    localparam logic [addr_w-1:0] obj_base  = 22'h020000;

    typedef enum logic [2:0] {
        rgn_cpu,
        rgn_snd,
        rgn_char,
        rgn_scr,
        rgn_obj
    } region_e;

    // region starts in 256-byte pages, counted from the end of the header.
    typedef struct packed {
        logic [15:0] snd_start;
        logic [15:0] char_start;
        logic [15:0] scr_start;
        logic [15:0] obj_start;
    } region_pages_t;

    typedef union packed {
        logic [7:0][7:0] bytes; // header bytes as they were shifted in.
        region_pages_t   pages; // the same word seen as four page starts.
    } region_starts_u;

    typedef struct packed {
        logic [addr_w-1:0] addr; // word address.
        logic [7:0]        data;
        logic [1:0]        mask; // active low, one bit per byte lane.
    } prog_req_t;

    typedef logic [1:0] rewrite_step_t;

endpackage

`default_nettype wire
